/* Bender.yml */
package:
  name: pipe_backend

sources:
  # design, packages first
  - files:
      - rtl/riscv_isa_pkg.sv
      - rtl/pipe_stage_pkg.sv
      - rtl/pipe_exe.sv
      - rtl/pipe_mem.sv
      - rtl/pipe_writeback.sv
      - rtl/pipe_backend.sv

  # testbench and bound assertions
  - target: simulation
    files:
      - sim/pipe_backend_sva.sv
      - sim/tb_pipe_backend.sv

/* rtl/pipe_backend.sv */
`timescale 1ns/1ps

module pipe_backend
    import riscv_isa_pkg::*;
    import pipe_stage_pkg::*;
#(
    parameter int DMEM_DEPTH_WORDS = 256  // data memory words, power of two
) (
    input  logic     clk,
    input  logic     resetn,
    input  id_exe_t  id_exe_i,       // from decode, every cycle
    input  reg_idx_t rf_rs1_idx_i,
    input  reg_idx_t rf_rs2_idx_i,
    output word_t    rf_rs1_data_o,
    output word_t    rf_rs2_data_o,
    output logic     illegal_o
);

    // ========================================================================
    // stage bundles
    // ========================================================================
    exe_mem_t exe_mem;
    mem_wb_t  mem_wb;

    pipe_exe i_exe (
        .clk       (clk),
        .resetn    (resetn),
        .id_exe_i  (id_exe_i),
        .exe_mem_o (exe_mem)
    );

    pipe_mem #(
        .DMEM_DEPTH_WORDS (DMEM_DEPTH_WORDS)
    ) i_mem (
        .clk       (clk),
        .resetn    (resetn),
        .exe_mem_i (exe_mem),
        .mem_wb_o  (mem_wb)
    );

    pipe_writeback i_wb (
        .clk           (clk),
        .resetn        (resetn),
        .mem_wb_i      (mem_wb),
        .rf_rs1_idx_i  (rf_rs1_idx_i),
        .rf_rs2_idx_i  (rf_rs2_idx_i),
        .rf_rs1_data_o (rf_rs1_data_o),
        .rf_rs2_data_o (rf_rs2_data_o),
        .illegal_o     (illegal_o)
    );

endmodule

/* rtl/pipe_exe.sv */
`timescale 1ns/1ps

module pipe_exe
    import riscv_isa_pkg::*;
    import pipe_stage_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  id_exe_t  id_exe_i,   // decoded bundle, one per cycle
    output exe_mem_t exe_mem_o   // EXE/MEM register
);

    word_t    alu_res;
    logic [4:0] shamt;
    exe_mem_t exe_d;

    assign shamt = id_exe_i.rs2_val[4:0];  // only low 5 bits shift

    // ========================================================================
    // ALU
    // ========================================================================
    always_comb begin
        case (id_exe_i.alu_op)
            ALU_ADD:  alu_res = id_exe_i.rs1_val + id_exe_i.rs2_val;
            ALU_SUB:  alu_res = id_exe_i.rs1_val - id_exe_i.rs2_val;
            ALU_AND:  alu_res = id_exe_i.rs1_val & id_exe_i.rs2_val;
            ALU_OR:   alu_res = id_exe_i.rs1_val | id_exe_i.rs2_val;
            ALU_XOR:  alu_res = id_exe_i.rs1_val ^ id_exe_i.rs2_val;
            ALU_SLL:  alu_res = id_exe_i.rs1_val << shamt;
            ALU_SRL:  alu_res = id_exe_i.rs1_val >> shamt;
            ALU_SRA:  alu_res = word_t'($signed(id_exe_i.rs1_val) >>> shamt);
            ALU_SLT:  alu_res = {31'b0, $signed(id_exe_i.rs1_val) < $signed(id_exe_i.rs2_val)};
            ALU_SLTU: alu_res = {31'b0, id_exe_i.rs1_val < id_exe_i.rs2_val};
            default:  alu_res = '0;  // unused opcodes
        endcase
    end

    // next EXE/MEM contents
    always_comb begin
        exe_d.alu_result    = alu_res;
        exe_d.store_data    = id_exe_i.store_data;
        exe_d.extended_imm  = id_exe_i.extended_imm;
        exe_d.pc_plus4      = id_exe_i.pc_plus4;
        exe_d.dmem_cmd      = id_exe_i.dmem_cmd;
        exe_d.dmem_type     = id_exe_i.dmem_type;
        exe_d.reg_write_en  = id_exe_i.reg_write_en;
        exe_d.rd_idx        = id_exe_i.rd_idx;
        exe_d.result_src    = id_exe_i.result_src;
        exe_d.instr_illegal = id_exe_i.instr_illegal;
        // illegal op retires with no side effect
        if (id_exe_i.instr_illegal) begin
            exe_d.reg_write_en = 1'b0;
            exe_d.dmem_cmd     = DMEM_NONE;
        end
    end

    // payload free-running, control fields forced to a bubble in reset
    always_ff @(posedge clk) begin
        exe_mem_o <= exe_d;
        if (!resetn) begin
            exe_mem_o.reg_write_en  <= 1'b0;
            exe_mem_o.dmem_cmd      <= DMEM_NONE;
            exe_mem_o.instr_illegal <= 1'b0;
        end
    end

endmodule

/* rtl/pipe_mem.sv */
`timescale 1ns/1ps

module pipe_mem
    import riscv_isa_pkg::*;
    import pipe_stage_pkg::*;
#(
    parameter int DMEM_DEPTH_WORDS = 256  // power of two
) (
    input  logic     clk,
    input  logic     resetn,
    input  exe_mem_t exe_mem_i,
    output mem_wb_t  mem_wb_o
);

    localparam int ADDR_W = $clog2(DMEM_DEPTH_WORDS);

    word_t             dmem_q [DMEM_DEPTH_WORDS];  // data ram, no reset
    logic [ADDR_W-1:0] word_addr;
    logic [1:0]        byte_off;
    logic [3:0]        byte_en;
    word_t             st_lanes;   // store data replicated over lanes
    mem_wb_t           wb_d;
    mem_wb_t           wb_q;       // load_data holds the raw ram word
    dmem_type_e        ld_type_q;
    word_t             ld_byte_w;
    word_t             ld_half_w;
    word_t             ld_ext;

    assign word_addr = exe_mem_i.alu_result[ADDR_W+1:2];
    assign byte_off  = exe_mem_i.alu_result[1:0];  // sub-width bits ignored

    // ========================================================================
    // store lanes
    // ========================================================================
    always_comb begin
        byte_en  = 4'b0000;
        st_lanes = exe_mem_i.store_data;
        case (exe_mem_i.dmem_type)
            DMEM_B, DMEM_BU: begin
                byte_en  = 4'b0001 << byte_off;
                st_lanes = {4{exe_mem_i.store_data[7:0]}};
            end
            DMEM_H, DMEM_HU: begin
                byte_en  = 4'b0011 << {byte_off[1], 1'b0};  // half aligned
                st_lanes = {2{exe_mem_i.store_data[15:0]}};
            end
            default: byte_en = 4'b1111;  // word
        endcase
        if (exe_mem_i.dmem_cmd != DMEM_STORE) begin
            byte_en = 4'b0000;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (byte_en[i]) begin
                dmem_q[word_addr][8*i +: 8] <= st_lanes[8*i +: 8];
            end
        end
    end

    // ========================================================================
    // MEM/WB register, ram read lands here
    // ========================================================================
    always_comb begin
        wb_d.alu_result    = exe_mem_i.alu_result;
        wb_d.load_data     = dmem_q[word_addr];  // registered below, sync read
        wb_d.extended_imm  = exe_mem_i.extended_imm;
        wb_d.pc_plus4      = exe_mem_i.pc_plus4;
        wb_d.reg_write_en  = exe_mem_i.reg_write_en;
        wb_d.rd_idx        = exe_mem_i.rd_idx;
        wb_d.result_src    = exe_mem_i.result_src;
        wb_d.instr_illegal = exe_mem_i.instr_illegal;
    end

    always_ff @(posedge clk) begin
        wb_q      <= wb_d;
        ld_type_q <= exe_mem_i.dmem_type;
        if (!resetn) begin
            wb_q.reg_write_en  <= 1'b0;
            wb_q.instr_illegal <= 1'b0;
        end
    end

    // load alignment and extension after the read
    assign ld_byte_w = wb_q.load_data >> {wb_q.alu_result[1:0], 3'b000};
    assign ld_half_w = wb_q.load_data >> {wb_q.alu_result[1], 4'b0000};

    always_comb begin
        case (ld_type_q)
            DMEM_B:  ld_ext = {{24{ld_byte_w[7]}}, ld_byte_w[7:0]};
            DMEM_BU: ld_ext = {24'b0, ld_byte_w[7:0]};
            DMEM_H:  ld_ext = {{16{ld_half_w[15]}}, ld_half_w[15:0]};
            DMEM_HU: ld_ext = {16'b0, ld_half_w[15:0]};
            default: ld_ext = wb_q.load_data;  // full word
        endcase
    end

    always_comb begin
        mem_wb_o           = wb_q;
        mem_wb_o.load_data = ld_ext;
    end

endmodule

/* rtl/pipe_stage_pkg.sv */
package pipe_stage_pkg;

    import riscv_isa_pkg::*;

    // ========================================================================
    // stage-to-stage bundles
    // ========================================================================

    // fully decoded instruction, operands already read and chosen
    typedef struct packed {
        alu_op_e     alu_op;
        word_t       rs1_val;        // operand 1
        word_t       rs2_val;        // operand 2, reg or imm
        word_t       store_data;     // rs2 value for stores
        word_t       extended_imm;
        word_t       pc_plus4;
        dmem_cmd_e   dmem_cmd;
        dmem_type_e  dmem_type;
        logic        reg_write_en;
        reg_idx_t    rd_idx;
        result_src_e result_src;
        logic        instr_illegal;
    } id_exe_t;

    typedef struct packed {
        word_t       alu_result;     // also the memory address
        word_t       store_data;
        word_t       extended_imm;
        word_t       pc_plus4;
        dmem_cmd_e   dmem_cmd;
        dmem_type_e  dmem_type;
        logic        reg_write_en;
        reg_idx_t    rd_idx;
        result_src_e result_src;
        logic        instr_illegal;  // kept for the retire flag
    } exe_mem_t;

    typedef struct packed {
        word_t       alu_result;
        word_t       load_data;      // already extended
        word_t       extended_imm;
        word_t       pc_plus4;
        logic        reg_write_en;
        reg_idx_t    rd_idx;
        result_src_e result_src;
        logic        instr_illegal;
    } mem_wb_t;

    // ========================================================================
    // register file ports
    // ========================================================================
    typedef struct packed {
        reg_idx_t idx;
        word_t    data;
    } rf_read_t;

    typedef struct packed {
        logic     we;
        reg_idx_t idx;
        word_t    data;
    } rf_write_t;

endpackage

/* rtl/pipe_writeback.sv */
`timescale 1ns/1ps

module pipe_writeback
    import riscv_isa_pkg::*;
    import pipe_stage_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  mem_wb_t  mem_wb_i,
    input  reg_idx_t rf_rs1_idx_i,
    input  reg_idx_t rf_rs2_idx_i,
    output word_t    rf_rs1_data_o,
    output word_t    rf_rs2_data_o,
    output logic     illegal_o      // one cycle per retired illegal op
);

    word_t     rf_q [32];
    rf_write_t wr;
    rf_read_t  rd_a;
    rf_read_t  rd_b;

    // ========================================================================
    // result select and write port
    // ========================================================================
    always_comb begin
        case (mem_wb_i.result_src)
            RES_MEM: wr.data = mem_wb_i.load_data;
            RES_IMM: wr.data = mem_wb_i.extended_imm;
            RES_PC4: wr.data = mem_wb_i.pc_plus4;
            default: wr.data = mem_wb_i.alu_result;
        endcase
        wr.idx = mem_wb_i.rd_idx;
        wr.we  = mem_wb_i.reg_write_en && (mem_wb_i.rd_idx != '0);  // x0 never written
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < 32; i++) begin
                rf_q[i] <= '0;
            end
        end else if (wr.we) begin
            rf_q[wr.idx] <= wr.data;
        end
    end

    // read ports, old value on same-cycle write
    always_comb begin
        rd_a.idx  = rf_rs1_idx_i;
        rd_a.data = (rd_a.idx == '0) ? '0 : rf_q[rd_a.idx];
        rd_b.idx  = rf_rs2_idx_i;
        rd_b.data = (rd_b.idx == '0) ? '0 : rf_q[rd_b.idx];
    end

    assign rf_rs1_data_o = rd_a.data;
    assign rf_rs2_data_o = rd_b.data;

    // retire flag
    always_ff @(posedge clk) begin
        if (!resetn) begin
            illegal_o <= 1'b0;
        end else begin
            illegal_o <= mem_wb_i.instr_illegal;
        end
    end

endmodule

/* rtl/riscv_isa_pkg.sv */
package riscv_isa_pkg;

    // ========================================================================
    // basic word and index types
    // ========================================================================
    typedef logic [31:0] word_t;     // data or address word
    typedef logic [4:0]  reg_idx_t;  // x0..x31

    // ========================================================================
    // ISA-level encodings
    // ========================================================================
    typedef enum logic [4:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_AND  = 5'd2,
        ALU_OR   = 5'd3,
        ALU_XOR  = 5'd4,
        ALU_SLL  = 5'd5,
        ALU_SRL  = 5'd6,
        ALU_SRA  = 5'd7,  // arithmetic, sign fills from the left
        ALU_SLT  = 5'd8,  // signed compare
        ALU_SLTU = 5'd9   // unsigned compare
    } alu_op_e;

    typedef enum logic [1:0] {
        DMEM_NONE  = 2'd0,  // bubble or non-memory op
        DMEM_LOAD  = 2'd1,
        DMEM_STORE = 2'd2
    } dmem_cmd_e;

    // same coding as funct3 of loads and stores
    typedef enum logic [2:0] {
        DMEM_B  = 3'b000,
        DMEM_H  = 3'b001,
        DMEM_W  = 3'b010,
        DMEM_BU = 3'b100,
        DMEM_HU = 3'b101
    } dmem_type_e;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,  // load data
        RES_IMM = 2'd2,  // lui style, extended immediate
        RES_PC4 = 2'd3   // link value
    } result_src_e;

endpackage

/* sim.f */
rtl/riscv_isa_pkg.sv
rtl/pipe_stage_pkg.sv
rtl/pipe_exe.sv
rtl/pipe_mem.sv
rtl/pipe_writeback.sv
rtl/pipe_backend.sv
sim/pipe_backend_sva.sv
sim/tb_pipe_backend.sv

/* sim/pipe_backend_sva.sv */
`timescale 1ns/1ps

module pipe_backend_sva
    import riscv_isa_pkg::*;
    import pipe_stage_pkg::*;
(
    input logic     clk,
    input logic     resetn,
    input id_exe_t  id_exe_i,
    input reg_idx_t rf_rs1_idx_i,
    input reg_idx_t rf_rs2_idx_i,
    input word_t    rf_rs1_data_o,
    input word_t    rf_rs2_data_o,
    input logic     illegal_o
);

    // ========================================================================
    // reset, x0 and retire flag
    // ========================================================================
    a_illegal_in_reset: assert property (@(posedge clk) !resetn |=> !illegal_o)
        else $error("illegal_o high in reset or in the first cycle after it");

    a_x0_port_a: assert property (@(posedge clk) (rf_rs1_idx_i == '0) |-> (rf_rs1_data_o == '0))
        else $error("port a reads nonzero for x0");

    a_x0_port_b: assert property (@(posedge clk) (rf_rs2_idx_i == '0) |-> (rf_rs2_data_o == '0))
        else $error("port b reads nonzero for x0");

    // exe, mem, wb registers, then the flag register
    a_illegal_latency: assert property (@(posedge clk) disable iff (!resetn)
        $past(resetn, 3) |-> (illegal_o == $past(id_exe_i.instr_illegal, 3)))
        else $error("illegal_o does not follow instr_illegal by three cycles");

endmodule

bind pipe_backend pipe_backend_sva i_sva (.*);

/* sim/tb_pipe_backend.sv */
`timescale 1ns/1ps

module tb_pipe_backend
    import riscv_isa_pkg::*;
    import pipe_stage_pkg::*;
();

    typedef struct packed {
        id_exe_t op;
        logic    rand_ops;     // rs1/rs2 replaced by random words
        logic    exp_illegal;  // retire flag expected
    } row_t;

    typedef struct packed {
        int   due;   // cycle count at the check
        logic flag;
    } ill_chk_t;

    logic       clk;
    logic       resetn;
    id_exe_t    id_exe;
    reg_idx_t   rs1_idx;
    reg_idx_t   rs2_idx;
    word_t      rs1_data;
    word_t      rs2_data;
    logic       illegal;
    row_t       tbl [$];
    ill_chk_t   ill_q [$];     // pending retire flag checks
    word_t      ref_rf [32];
    logic [7:0] ref_mem [word_t];  // byte addressed
    int         cyc = 0;
    int         limit = 1000;

    pipe_backend #(
        .DMEM_DEPTH_WORDS (256)
    ) i_dut (
        .clk           (clk),
        .resetn        (resetn),
        .id_exe_i      (id_exe),
        .rf_rs1_idx_i  (rs1_idx),
        .rf_rs2_idx_i  (rs2_idx),
        .rf_rs1_data_o (rs1_data),
        .rf_rs2_data_o (rs2_data),
        .illegal_o     (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= limit) begin
            $display("timeout: run still going after %0d cycles", limit);
            $display("ERRORS FOUND");
            $fatal(1, "run stopped by cycle limit");
        end
    end

    // ========================================================================
    // reference model
    // ========================================================================
    function automatic word_t alu_ref(alu_op_e op, word_t a, word_t b);
        logic [4:0] sh;
        sh = b[4:0];  // shift amount from low bits only
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 32'd1;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            ALU_SLT:  return (a[31] != b[31]) ? word_t'(a[31]) : word_t'(a < b);
            ALU_SLTU: return word_t'(a < b);
            default:  return 32'h0;
        endcase
    endfunction

    task automatic store_ref(dmem_type_e t, word_t addr, word_t data);
        case (t)
            DMEM_B, DMEM_BU: ref_mem[addr] = data[7:0];
            DMEM_H, DMEM_HU: begin
                for (int i = 0; i < 2; i++) begin
                    ref_mem[{addr[31:1], 1'b0} + i] = data[8*i +: 8];
                end
            end
            default: begin
                for (int i = 0; i < 4; i++) begin
                    ref_mem[{addr[31:2], 2'b00} + i] = data[8*i +: 8];
                end
            end
        endcase
    endtask

    function automatic word_t load_ref(dmem_type_e t, word_t addr);
        word_t       wa;
        word_t       ha;
        logic [7:0]  b0;
        logic [15:0] h0;
        wa = {addr[31:2], 2'b00};
        ha = {addr[31:1], 1'b0};
        b0 = ref_mem[addr];
        h0 = {ref_mem[ha + 1], ref_mem[ha]};  // little endian
        case (t)
            DMEM_B:  return {{24{b0[7]}}, b0};
            DMEM_BU: return {24'h0, b0};
            DMEM_H:  return {{16{h0[15]}}, h0};
            DMEM_HU: return {16'h0, h0};
            default: return {ref_mem[wa + 3], ref_mem[wa + 2], ref_mem[wa + 1], ref_mem[wa]};
        endcase
    endfunction

    // program order, so a load sees every earlier store
    task automatic model_update(id_exe_t op);
        word_t addr;
        word_t res;
        addr = alu_ref(op.alu_op, op.rs1_val, op.rs2_val);
        res  = addr;
        if (!op.instr_illegal) begin
            if (op.dmem_cmd == DMEM_STORE) begin
                store_ref(op.dmem_type, addr, op.store_data);
            end
            case (op.result_src)
                RES_MEM: res = load_ref(op.dmem_type, addr);
                RES_IMM: res = op.extended_imm;
                RES_PC4: res = op.pc_plus4;
                default: res = addr;
            endcase
            if (op.reg_write_en && op.rd_idx != 5'd0) begin
                ref_rf[op.rd_idx] = res;
            end
        end
    endtask

    // ========================================================================
    // stimulus table
    // ========================================================================
    function automatic row_t base_row();
        row_t r;
        r = '0;  // bubble
        r.op.pc_plus4     = 32'h0000_1004 + 4 * tbl.size();
        r.op.extended_imm = 32'hfff0_0000 ^ tbl.size();
        r.op.store_data   = 32'h5a5a_5a5a;
        return r;
    endfunction

    function automatic row_t alu_row(alu_op_e op, word_t a, word_t b, reg_idx_t rd,
                                     logic rnd);
        row_t r;
        r = base_row();
        r.op.alu_op       = op;
        r.op.rs1_val      = a;
        r.op.rs2_val      = b;
        r.op.reg_write_en = 1'b1;
        r.op.rd_idx       = rd;
        r.rand_ops        = rnd;
        return r;
    endfunction

    function automatic row_t mem_row(dmem_cmd_e cmd, dmem_type_e t, word_t addr,
                                     word_t data, reg_idx_t rd);
        row_t r;
        r = base_row();
        r.op.rs1_val    = addr;  // address = rs1 + 0
        r.op.dmem_cmd   = cmd;
        r.op.dmem_type  = t;
        r.op.store_data = data;
        if (cmd == DMEM_LOAD) begin
            r.op.reg_write_en = 1'b1;
            r.op.rd_idx       = rd;
            r.op.result_src   = RES_MEM;
        end
        return r;
    endfunction

    task automatic build_table();
        row_t r;
        // corner operands, sign boundaries and shifts by 31 and 0
        tbl.push_back(alu_row(ALU_ADD, 32'h7fff_ffff, 32'h1, 5'd1, 1'b0));
        tbl.push_back(alu_row(ALU_SUB, 32'h0, 32'h1, 5'd2, 1'b0));
        tbl.push_back(alu_row(ALU_AND, 32'hf0f0_ff00, 32'h0ff0_f0ff, 5'd3, 1'b0));
        tbl.push_back(alu_row(ALU_OR, 32'hf0f0_ff00, 32'h0ff0_f0ff, 5'd4, 1'b0));
        tbl.push_back(alu_row(ALU_XOR, 32'hf0f0_ff00, 32'h0ff0_f0ff, 5'd5, 1'b0));
        tbl.push_back(alu_row(ALU_SLL, 32'h8000_0001, 32'd31, 5'd6, 1'b0));
        tbl.push_back(alu_row(ALU_SLL, 32'h8000_0001, 32'hffff_ffe0, 5'd7, 1'b0));
        tbl.push_back(alu_row(ALU_SRL, 32'h8000_0000, 32'd31, 5'd8, 1'b0));
        tbl.push_back(alu_row(ALU_SRA, 32'h8000_0000, 32'd31, 5'd9, 1'b0));
        tbl.push_back(alu_row(ALU_SRA, 32'h8000_0000, 32'h20, 5'd10, 1'b0));
        tbl.push_back(alu_row(ALU_SLT, 32'h8000_0000, 32'h1, 5'd11, 1'b0));
        tbl.push_back(alu_row(ALU_SLTU, 32'h8000_0000, 32'h1, 5'd12, 1'b0));
        for (int k = 0; k < 10; k++) begin
            tbl.push_back(alu_row(alu_op_e'(k), '0, '0, reg_idx_t'(13 + k), 1'b1));
        end
        r = alu_row(ALU_SUB, '0, '0, 5'd23, 1'b1);
        r.op.result_src   = RES_IMM;
        r.op.extended_imm = 32'hdead_b000;
        tbl.push_back(r);
        r = alu_row(ALU_XOR, '0, '0, 5'd24, 1'b1);
        r.op.result_src = RES_PC4;
        tbl.push_back(r);
        r = alu_row(ALU_ADD, 32'h1, 32'h1, 5'd1, 1'b0);  // x1 must survive
        r.op.instr_illegal = 1'b1;
        r.exp_illegal      = 1'b1;
        tbl.push_back(r);
        // stores, with a load right behind the first one
        tbl.push_back(mem_row(DMEM_STORE, DMEM_W, 32'h40, 32'h8899_aabb, 5'd0));
        tbl.push_back(mem_row(DMEM_LOAD, DMEM_W, 32'h40, '0, 5'd25));
        tbl.push_back(mem_row(DMEM_STORE, DMEM_W, 32'h44, 32'h1122_3344, 5'd0));
        tbl.push_back(mem_row(DMEM_STORE, DMEM_B, 32'h41, 32'h1234_56e5, 5'd0));
        tbl.push_back(mem_row(DMEM_STORE, DMEM_H, 32'h46, 32'h7777_8001, 5'd0));
        r = mem_row(DMEM_STORE, DMEM_W, 32'h44, 32'hdead_beef, 5'd0);
        r.op.instr_illegal = 1'b1;
        r.exp_illegal      = 1'b1;
        tbl.push_back(r);
        tbl.push_back(mem_row(DMEM_LOAD, DMEM_B, 32'h41, '0, 5'd26));
        tbl.push_back(mem_row(DMEM_LOAD, DMEM_BU, 32'h41, '0, 5'd27));
        tbl.push_back(mem_row(DMEM_LOAD, DMEM_H, 32'h46, '0, 5'd28));
        tbl.push_back(mem_row(DMEM_LOAD, DMEM_HU, 32'h46, '0, 5'd29));
        tbl.push_back(mem_row(DMEM_LOAD, DMEM_B, 32'h43, '0, 5'd30));
        tbl.push_back(mem_row(DMEM_LOAD, DMEM_W, 32'h44, '0, 5'd31));
        tbl.push_back(alu_row(ALU_ADD, '0, '0, 5'd0, 1'b1));   // x0 target
        r = alu_row(ALU_OR, '0, '0, 5'd5, 1'b1);
        r.op.reg_write_en = 1'b0;  // bubble with a stale rd
        tbl.push_back(r);
    endtask

    // ========================================================================
    // drive and compare
    // ========================================================================
    task automatic apply_row(row_t r);
        id_exe_t  op;
        ill_chk_t c;
        op = r.op;
        if (r.rand_ops) begin
            op.rs1_val = $urandom;
            op.rs2_val = $urandom;
        end
        @(posedge clk);
        #1;
        id_exe = op;
        c.due  = cyc + 3;  // retires three edges later
        c.flag = r.exp_illegal;
        ill_q.push_back(c);
        model_update(op);
    endtask

    task automatic check_reg(reg_idx_t idx, word_t observed, word_t expected);
        if (observed !== expected) begin
            $display("error: x%0d read 0x%08h, expected 0x%08h", idx, observed, expected);
            $display("ERRORS FOUND");
            $fatal(1, "register mismatch");
        end
    endtask

    task automatic check_illegal(logic observed, logic expected);
        if (observed !== expected) begin
            $display("error: illegal_o 0x%0h, expected 0x%0h at cycle %0d",
                     observed, expected, cyc);
            $display("ERRORS FOUND");
            $fatal(1, "retire flag mismatch");
        end
    endtask

    // 16 reads cover each register once, 32 cover each on both ports
    task automatic check_all_regs(int n_reads);
        for (int i = 0; i < n_reads; i++) begin
            @(posedge clk);
            #1;
            rs1_idx = reg_idx_t'(i);
            rs2_idx = reg_idx_t'(31 - i);
            #2;  // read ports are combinational
            check_reg(rs1_idx, rs1_data, ref_rf[i]);
            check_reg(rs2_idx, rs2_data, ref_rf[31 - i]);
        end
    endtask

    initial begin : illegal_watch
        ill_chk_t c;
        logic     exp_flag;
        wait (resetn === 1'b1);
        forever begin
            @(negedge clk);
            exp_flag = 1'b0;  // low on every cycle with no retire due
            if (ill_q.size() > 0 && ill_q[0].due == cyc) begin
                c        = ill_q.pop_front();
                exp_flag = c.flag;
            end
            check_illegal(illegal, exp_flag);
        end
    end

    initial begin
        int seed_dummy;
        seed_dummy = $urandom(32'ha54d48bc);
        resetn     = 1'b0;
        id_exe     = '0;
        rs1_idx    = '0;
        rs2_idx    = '0;
        for (int i = 0; i < 32; i++) begin
            ref_rf[i] = '0;
        end
        build_table();
        limit = tbl.size() + 64 + 16;
        repeat (16) @(posedge clk);
        #1;
        resetn = 1'b1;
        check_all_regs(16);  // cleared by reset
        foreach (tbl[i]) begin
            apply_row(tbl[i]);
        end
        repeat (4) apply_row('0);  // drain
        check_all_regs(32);
        $display("NO ERRORS");
        $finish;
    end

endmodule
